// File: project.f
rtl/rv_decode_pkg.sv
rtl/control_decoder.sv
rtl/branch_comparator.sv
rtl/pc_redirect.sv
rtl/rv_decode_top.sv
tb/rv_decode_chk.sv
tb/tb_rv_decode.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the decode testbench with verilator, verdict from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_rv_decode -f project.f -o sim_rv_decode

./obj_dir/sim_rv_decode +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a verdict, see sim.log"
    exit 1
fi

echo "simulation passed"

// File: tb/tb_rv_decode.sv
/*
    testbench for the decode control top
    random instruction words per class, one per cycle, results are
    checked by the bound assertion module
*/

`timescale 1ns/1ps

module tb_rv_decode;

    localparam int XLEN       = 64;
    localparam int MAX_CYCLES = 2000; // six tests of at most 250 cycles plus margin

    logic            clk = 1'b0;
    logic            arst_n;
    logic            inst_valid;
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            out_valid;
    logic            reg_write_q;
    logic            mem_write_q;
    logic            alu_src_q;
    logic            result_src_q;
    logic [XLEN-1:0] imm_ext;
    logic            pc_src;
    logic [XLEN-1:0] target_pc;
    logic [XLEN-1:0] link_pc;
    logic            illegal_q;

    logic [31:0] seed = 32'h5ae4;
    int          cycles = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          err_mark = 0; // checker count at start of test

    rv_decode_top #(.XLEN(XLEN)) dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .out_valid    (out_valid),
        .reg_write_q  (reg_write_q),
        .mem_write_q  (mem_write_q),
        .alu_src_q    (alu_src_q),
        .result_src_q (result_src_q),
        .imm_ext      (imm_ext),
        .pc_src       (pc_src),
        .target_pc    (target_pc),
        .link_pc      (link_pc),
        .illegal_q    (illegal_q)
    );

    always #20 clk = ~clk; // 40 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        seed = xorshift(seed);
        r    = seed;
    endtask

    task automatic rand_word(output logic [XLEN-1:0] r);
        logic [31:0] hi;
        logic [31:0] lo;
        next_rand(hi);
        next_rand(lo);
        r = {hi, lo};
    endtask

    // one word on the next falling edge with random pc and operands
    task automatic issue(input logic [31:0] w, input logic same);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] p;
        rand_word(a);
        rand_word(b);
        rand_word(p);
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = w;
        pc         = {p[XLEN-1:2], 2'b00}; // word aligned
        rs1_data   = a;
        rs2_data   = same ? a : b; // equal pair for beq/bge corners
    endtask

    task automatic close_test(input string name);
        int              errs;
        logic [31:0]     r;
        logic [XLEN-1:0] p;
        next_rand(r);
        rand_word(p);
        @(negedge clk);
        inst_valid = 1'b0; // last word gets checked on the next edge
        inst       = r;    // fresh idle inputs, data outputs must hold
        pc         = {p[XLEN-1:2], 2'b00};
        rs1_data   = ~p;
        rs2_data   = p;
        repeat (2) @(negedge clk);
        errs     = dut0.chk0.err_cnt - err_mark;
        err_mark = dut0.chk0.err_cnt;
        if (errs == 0) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("test %-12s done, %0d errors", name, errs);
    endtask

    task automatic reset_and_idle();
        logic [31:0] r;
        repeat (3) @(negedge clk); // idle right after release
        next_rand(r);
        issue({r[31:7], rv_decode_pkg::op_load}, 1'b0);
        close_test("reset_idle");
    endtask

    task automatic control_table();
        logic [31:0] r;
        logic [6:0]  opc;
        for (int i = 0; i < 48; i++) begin
            next_rand(r);
            case (i % 6)
                0: opc = rv_decode_pkg::op_load;
                1: opc = rv_decode_pkg::op_imm;
                2: opc = rv_decode_pkg::op_imm_32;
                3: opc = rv_decode_pkg::op_store;
                4: opc = rv_decode_pkg::op_32;
                default: opc = rv_decode_pkg::op;
            endcase
            issue({r[31:7], opc}, 1'b0);
        end
        close_test("controls");
    endtask

    task automatic immediate_forms();
        logic [31:0] r;
        logic [6:0]  opc;
        for (int i = 0; i < 40; i++) begin
            next_rand(r);
            case (i % 5)
                0: opc = rv_decode_pkg::op_imm;    // i
                1: opc = rv_decode_pkg::op_load;   // i
                2: opc = rv_decode_pkg::op_store;  // s
                3: opc = rv_decode_pkg::op_branch; // b
                default: opc = rv_decode_pkg::op_jal; // j
            endcase
            issue({r[31:7], opc}, 1'b0);
        end
        close_test("immediates");
    endtask

    task automatic branch_conditions();
        logic [31:0] r;
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                for (int k = 0; k < 8; k++) begin
                    next_rand(r);
                    issue({r[31:15], 3'(f), r[11:7], rv_decode_pkg::op_branch}, k[0]);
                end
            end
        end
        close_test("branches");
    endtask

    task automatic jump_targets();
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            next_rand(r);
            if (i < 16) begin
                issue({r[31:7], rv_decode_pkg::op_jal}, 1'b0);
            end else begin
                issue({r[31:15], 3'b000, r[11:7], rv_decode_pkg::op_jalr}, 1'b0);
            end
        end
        close_test("jumps");
    endtask

    task automatic illegal_words();
        logic [31:0] r;
        logic [6:0]  opc;
        for (int i = 0; i < 40; i++) begin
            next_rand(r);
            opc = r[6:0];
            case (i % 4)
                0: opc = 7'b0110111; // lui
                1: opc = 7'b0010111; // auipc
                2: begin
                    if (opc inside {rv_decode_pkg::op_load, rv_decode_pkg::op_imm,
                                    rv_decode_pkg::op_imm_32, rv_decode_pkg::op_jalr,
                                    rv_decode_pkg::op_store, rv_decode_pkg::op,
                                    rv_decode_pkg::op_32, rv_decode_pkg::op_branch,
                                    rv_decode_pkg::op_jal}) begin
                        opc = 7'b1111111; // defined opcode swapped for an undefined one
                    end
                end
                default: begin
                    opc       = rv_decode_pkg::op_branch;
                    r[14:12]  = {2'b01, r[0]}; // funct3 2 or 3
                end
            endcase
            issue({r[31:7], opc}, 1'b0); // back to back so out_valid stays high
        end
        close_test("illegal");
    endtask

    initial begin
        arst_n     = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        rs1_data   = '0;
        rs2_data   = '0;
        #1;
        arst_n = 1'b0; // held for 10 cycles
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        reset_and_idle();
        control_table();
        immediate_forms();
        branch_conditions();
        jump_targets();
        illegal_words();
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb/rv_decode_chk.sv
/*
    decode output checker, bound into rv_decode_top
    recomputes each registered result from the inputs one cycle back
*/

`timescale 1ns/1ps

module rv_decode_chk #(
    parameter int XLEN = 64
) (
    input logic            clk,
    input logic            arst_n,
    input logic            inst_valid,
    input logic [31:0]     inst,
    input logic [XLEN-1:0] pc,
    input logic [XLEN-1:0] rs1_data,
    input logic [XLEN-1:0] rs2_data,
    input logic            out_valid,
    input logic            reg_write_q,
    input logic            mem_write_q,
    input logic            alu_src_q,
    input logic            result_src_q,
    input logic [XLEN-1:0] imm_ext,
    input logic            pc_src,
    input logic [XLEN-1:0] target_pc,
    input logic [XLEN-1:0] link_pc,
    input logic            illegal_q
);

    logic [5:0]      exp_ctrl;   // rw mw as rs pcs ill
    logic [2:0]      exp_fmt;    // known opcode, imm format
    logic [XLEN-1:0] exp_imm;
    logic [XLEN-1:0] exp_target;
    logic [5:0]      ctrl_q;
    int              err_cnt = 0;

    // expected control row, branch condition folded in
    function automatic logic [5:0] ctrl_of(input logic [31:0] w, input logic [XLEN-1:0] a,
                                           input logic [XLEN-1:0] b);
        logic t;
        t = 1'b0;
        case (w[14:12])
            3'd0: t = (a == b);
            3'd1: t = (a != b);
            3'd4: t = ($signed(a) < $signed(b));
            3'd5: t = ($signed(a) >= $signed(b));
            3'd6: t = (a < b);
            3'd7: t = (a >= b);
            default: t = 1'b0; // 2 and 3 are not branches
        endcase
        case (w[6:0])
            rv_decode_pkg::op_load:   return 6'b101100;
            rv_decode_pkg::op_imm:    return 6'b101000;
            rv_decode_pkg::op_jalr:   return 6'b101010;
            rv_decode_pkg::op_store:  return 6'b011000;
            rv_decode_pkg::op:        return 6'b100000;
            rv_decode_pkg::op_jal:    return 6'b100010;
            rv_decode_pkg::op_imm_32: return (XLEN == 64) ? 6'b101000 : 6'b000001;
            rv_decode_pkg::op_32:     return (XLEN == 64) ? 6'b100000 : 6'b000001;
            rv_decode_pkg::op_branch: return (w[14:13] == 2'b01) ? 6'b000001 : {4'b0000, t, 1'b0};
            default:                  return 6'b000001; // u-type and unknown
        endcase
    endfunction

    function automatic logic [2:0] fmt_of(input logic [6:0] opc);
        case (opc)
            rv_decode_pkg::op_store:  return {1'b1, rv_decode_pkg::imm_s};
            rv_decode_pkg::op_branch: return {1'b1, rv_decode_pkg::imm_b};
            rv_decode_pkg::op_jal:    return {1'b1, rv_decode_pkg::imm_j};
            rv_decode_pkg::op_load, rv_decode_pkg::op_imm,
            rv_decode_pkg::op_jalr, rv_decode_pkg::op: return {1'b1, rv_decode_pkg::imm_i};
            rv_decode_pkg::op_imm_32, rv_decode_pkg::op_32: return (XLEN == 64) ? 3'b100 : 3'b000;
            default: return 3'b000;
        endcase
    endfunction

    // field layout straight from the isa encoding
    function automatic logic [XLEN-1:0] imm_of(input logic [31:0] w, input logic [1:0] fmt);
        case (fmt)
            rv_decode_pkg::imm_s: return {{(XLEN-12){w[31]}}, w[31:25], w[11:7]};
            rv_decode_pkg::imm_b: return {{(XLEN-12){w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            rv_decode_pkg::imm_j: return {{(XLEN-20){w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:              return {{(XLEN-12){w[31]}}, w[31:20]};
        endcase
    endfunction

    always_comb begin
        exp_ctrl = ctrl_of(inst, rs1_data, rs2_data);
        exp_fmt  = fmt_of(inst[6:0]);
        exp_imm  = imm_of(inst, exp_fmt[1:0]);
        if (inst[6:0] == rv_decode_pkg::op_jalr) begin
            exp_target = (rs1_data + exp_imm) & ~{{(XLEN-1){1'b0}}, 1'b1}; // lsb dropped
        end else begin
            exp_target = pc + exp_imm;
        end
    end

    assign ctrl_q = {reg_write_q, mem_write_q, alu_src_q, result_src_q, pc_src, illegal_q};

    a_reset: assert property (@(posedge clk)
        !arst_n |-> ctrl_q == 6'b0 && !out_valid && imm_ext == '0 && target_pc == '0
                    && link_pc == '0)
        else begin
            $error("error at %0t: outputs not cleared during reset", $time);
            err_cnt++;
        end

    a_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !$past(inst_valid) |-> !out_valid && ctrl_q == 6'b0 && $stable(imm_ext)
                               && $stable(target_pc) && $stable(link_pc))
        else begin
            $error("error at %0t: idle cycle changed outputs or left controls high", $time);
            err_cnt++;
        end

    a_ctrl: assert property (@(posedge clk) disable iff (!arst_n)
        $past(inst_valid) |-> out_valid && ctrl_q == $past(exp_ctrl))
        else begin
            $error("error at %0t: wrong out_valid or controls %b", $time, ctrl_q);
            err_cnt++;
        end

    a_link: assert property (@(posedge clk) disable iff (!arst_n)
        $past(inst_valid) |-> link_pc == $past(pc) + 4)
        else begin
            $error("error at %0t: link_pc %h is not pc + 4", $time, link_pc);
            err_cnt++;
        end

    a_imm_target: assert property (@(posedge clk) disable iff (!arst_n)
        $past(inst_valid && exp_fmt[2]) |-> imm_ext == $past(exp_imm)
                                            && target_pc == $past(exp_target))
        else begin
            $error("error at %0t: imm_ext %h or target_pc %h wrong", $time, imm_ext, target_pc);
            err_cnt++;
        end

endmodule

bind rv_decode_top rv_decode_chk #(.XLEN(XLEN)) chk0 (.*);

// File: rtl/rv_decode_top.sv
/*
    rv64i decode control top
    control decoder and branch comparator in parallel, both feeding
    the registered redirect stage
*/

`timescale 1ns/1ps

module rv_decode_top #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            inst_valid,
    input  logic [31:0]     inst,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic            out_valid,
    output logic            reg_write_q,
    output logic            mem_write_q,
    output logic            alu_src_q,
    output logic            result_src_q,
    output logic [XLEN-1:0] imm_ext,
    output logic            pc_src,
    output logic [XLEN-1:0] target_pc,
    output logic [XLEN-1:0] link_pc,
    output logic            illegal_q
);

    rv_decode_pkg::inst_u inst_w;

    logic       reg_write;
    logic       mem_write;
    logic       alu_src;
    logic       result_src;
    logic [1:0] imm_src;
    logic       is_branch;
    logic       is_jump;
    logic       is_jalr;
    logic       illegal;
    logic       take;
    logic       cond_bad;

    assign inst_w = inst; // field view for the side blocks

    control_decoder #(.XLEN(XLEN)) u_ctrl (
        .opcode     (inst_w.r_fmt.opcode),
        .reg_write  (reg_write),
        .mem_write  (mem_write),
        .alu_src    (alu_src),
        .result_src (result_src),
        .imm_src    (imm_src),
        .is_branch  (is_branch),
        .is_jump    (is_jump),
        .is_jalr    (is_jalr),
        .illegal    (illegal)
    );

    branch_comparator #(.XLEN(XLEN)) u_cmp (
        .funct3   (inst_w.b_fmt.funct3),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .take     (take),
        .cond_bad (cond_bad)
    );

    pc_redirect #(.XLEN(XLEN)) u_redir (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .reg_write    (reg_write),
        .mem_write    (mem_write),
        .alu_src      (alu_src),
        .result_src   (result_src),
        .imm_src      (imm_src),
        .is_branch    (is_branch),
        .is_jump      (is_jump),
        .is_jalr      (is_jalr),
        .illegal      (illegal),
        .take         (take),
        .cond_bad     (cond_bad),
        .out_valid    (out_valid),
        .reg_write_q  (reg_write_q),
        .mem_write_q  (mem_write_q),
        .alu_src_q    (alu_src_q),
        .result_src_q (result_src_q),
        .imm_ext      (imm_ext),
        .pc_src       (pc_src),
        .target_pc    (target_pc),
        .link_pc      (link_pc),
        .illegal_q    (illegal_q)
    );

endmodule

// File: rtl/pc_redirect.sv
/*
    redirect and output stage
    builds the sign-extended immediate, forms pc_src, target and link,
    registers the whole result set for each valid instruction
*/

`timescale 1ns/1ps

module pc_redirect #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            inst_valid,
    input  logic [31:0]     inst,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic            reg_write,
    input  logic            mem_write,
    input  logic            alu_src,
    input  logic            result_src,
    input  logic [1:0]      imm_src,
    input  logic            is_branch,
    input  logic            is_jump,
    input  logic            is_jalr,
    input  logic            illegal,
    input  logic            take,
    input  logic            cond_bad,
    output logic            out_valid,
    output logic            reg_write_q,
    output logic            mem_write_q,
    output logic            alu_src_q,
    output logic            result_src_q,
    output logic [XLEN-1:0] imm_ext,
    output logic            pc_src,
    output logic [XLEN-1:0] target_pc,
    output logic [XLEN-1:0] link_pc,
    output logic            illegal_q
);

    rv_decode_pkg::inst_u inst_w;

    logic [XLEN-1:0] imm_d;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] target_d;
    logic [XLEN-1:0] link_d;
    logic            bad_d;
    logic            pc_src_d;

    assign inst_w = inst;

    // immediate reassembly, sign bit is always inst[31]
    always_comb begin
        case (imm_src)
            rv_decode_pkg::imm_i: begin
                imm_d = {{(XLEN-12){inst_w.i_fmt.imm_11_0[11]}}, inst_w.i_fmt.imm_11_0};
            end
            rv_decode_pkg::imm_s: begin
                imm_d = {{(XLEN-12){inst_w.s_fmt.imm_11_5[6]}},
                         inst_w.s_fmt.imm_11_5, inst_w.s_fmt.imm_4_0};
            end
            rv_decode_pkg::imm_b: begin
                imm_d = {{(XLEN-13){inst_w.b_fmt.imm_12}}, inst_w.b_fmt.imm_12,
                         inst_w.b_fmt.imm_11, inst_w.b_fmt.imm_10_5,
                         inst_w.b_fmt.imm_4_1, 1'b0};
            end
            default: begin // imm_j
                imm_d = {{(XLEN-21){inst_w.j_fmt.imm_20}}, inst_w.j_fmt.imm_20,
                         inst_w.j_fmt.imm_19_12, inst_w.j_fmt.imm_11,
                         inst_w.j_fmt.imm_10_1, 1'b0};
            end
        endcase
    end

    assign bad_d    = illegal | (is_branch & cond_bad); // bad funct3 on a branch
    assign pc_src_d = ((is_branch & take & ~cond_bad) | is_jump) & ~bad_d;

    assign base     = is_jalr ? rs1_data : pc;
    assign sum      = base + imm_d;
    assign target_d = is_jalr ? {sum[XLEN-1:1], 1'b0} : sum; // jalr clears bit 0
    assign link_d   = pc + {{(XLEN-3){1'b0}}, 3'd4};

    // control side, low on idle cycles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid    <= 1'b0;
            reg_write_q  <= 1'b0;
            mem_write_q  <= 1'b0;
            alu_src_q    <= 1'b0;
            result_src_q <= 1'b0;
            pc_src       <= 1'b0;
            illegal_q    <= 1'b0;
        end else begin
            out_valid    <= inst_valid;
            reg_write_q  <= inst_valid & reg_write & ~bad_d; // no writeback if illegal
            mem_write_q  <= inst_valid & mem_write & ~bad_d;
            alu_src_q    <= inst_valid & alu_src;
            result_src_q <= inst_valid & result_src;
            pc_src       <= inst_valid & pc_src_d;
            illegal_q    <= inst_valid & bad_d;
        end
    end

    // data side, holds last result when idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            imm_ext   <= '0;
            target_pc <= '0;
            link_pc   <= '0;
        end else if (inst_valid) begin
            imm_ext   <= imm_d;
            target_pc <= target_d;
            link_pc   <= link_d; // pc + 4
        end
    end

endmodule

// File: rtl/branch_comparator.sv
/*
    branch condition unit
    compares rs1/rs2 and picks the result by funct3
*/

`timescale 1ns/1ps

module branch_comparator #(
    parameter int XLEN = 64
) (
    input  logic [2:0]      funct3,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    output logic            take,
    output logic            cond_bad
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data)); // blt/bge
    assign ltu = (rs1_data < rs2_data);                   // bltu/bgeu

    always_comb begin
        take     = 1'b0;
        cond_bad = 1'b0;
        case (funct3)
            rv_decode_pkg::f3_beq: begin
                take = eq;
            end
            rv_decode_pkg::f3_bne: begin
                take = ~eq;
            end
            rv_decode_pkg::f3_blt: begin
                take = lt;
            end
            rv_decode_pkg::f3_bge: begin
                take = ~lt; // ge is not lt
            end
            rv_decode_pkg::f3_bltu: begin
                take = ltu;
            end
            rv_decode_pkg::f3_bgeu: begin
                take = ~ltu;
            end
            default: begin
                cond_bad = 1'b1; // funct3 2 or 3, take stays low
            end
        endcase
    end

endmodule

// File: rtl/control_decoder.sv
/*
    main control decoder
    maps the opcode to datapath enables, the immediate layout and
    branch/jump class, flags anything it does not know as illegal
*/

`timescale 1ns/1ps

module control_decoder #(
    parameter int XLEN = 64
) (
    input  logic [6:0] opcode,
    output logic       reg_write,
    output logic       mem_write,
    output logic       alu_src,    // 1 selects immediate as alu operand b
    output logic       result_src, // 1 selects memory read data
    output logic [1:0] imm_src,
    output logic       is_branch,
    output logic       is_jump,
    output logic       is_jalr,
    output logic       illegal
);

    always_comb begin
        reg_write  = 1'b0; // everything low unless set below
        mem_write  = 1'b0;
        alu_src    = 1'b0;
        result_src = 1'b0;
        imm_src    = rv_decode_pkg::imm_i;
        is_branch  = 1'b0;
        is_jump    = 1'b0;
        is_jalr    = 1'b0;
        illegal    = 1'b0;

        case (opcode)
            rv_decode_pkg::op_load: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1; // base + offset
                result_src = 1'b1; // rd from memory
                imm_src    = rv_decode_pkg::imm_i;
            end
            rv_decode_pkg::op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = rv_decode_pkg::imm_i;
            end
            rv_decode_pkg::op_imm_32: begin
                if (XLEN == 64) begin // addiw and friends
                    reg_write = 1'b1;
                    alu_src   = 1'b1;
                    imm_src   = rv_decode_pkg::imm_i;
                end else begin
                    illegal = 1'b1; // no word ops on rv32
                end
            end
            rv_decode_pkg::op_jalr: begin
                reg_write = 1'b1; // rd gets the link
                alu_src   = 1'b1;
                imm_src   = rv_decode_pkg::imm_i;
                is_jump   = 1'b1;
                is_jalr   = 1'b1; // target from rs1
            end
            rv_decode_pkg::op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = rv_decode_pkg::imm_s;
            end
            rv_decode_pkg::op: begin
                reg_write = 1'b1; // rs2 as operand b
            end
            rv_decode_pkg::op_32: begin
                if (XLEN == 64) begin
                    reg_write = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            rv_decode_pkg::op_branch: begin
                is_branch = 1'b1; // compare rs1/rs2
                imm_src   = rv_decode_pkg::imm_b;
            end
            rv_decode_pkg::op_jal: begin
                reg_write = 1'b1;
                imm_src   = rv_decode_pkg::imm_j;
                is_jump   = 1'b1;
            end
            default: begin
                illegal = 1'b1; // incl. lui/auipc
            end
        endcase
    end

endmodule

// File: rtl/rv_decode_pkg.sv
/*
    rv64i decode shared definitions
    opcodes, immediate format codes, branch funct3 codes and
    the instruction word union used to pick fields per format
*/

package rv_decode_pkg;

    // major opcodes handled by the decoder
    localparam logic [6:0] op_load   = 7'b0000011; // 3
    localparam logic [6:0] op_imm    = 7'b0010011; // 19
    localparam logic [6:0] op_imm_32 = 7'b0011011; // 27, word ops
    localparam logic [6:0] op_jalr   = 7'b1100111; // 103
    localparam logic [6:0] op_store  = 7'b0100011; // 35
    localparam logic [6:0] op        = 7'b0110011; // 51
    localparam logic [6:0] op_32     = 7'b0111011; // 59, word ops
    localparam logic [6:0] op_branch = 7'b1100011; // 99
    localparam logic [6:0] op_jal    = 7'b1101111; // 111

    // immediate layouts
    localparam logic [1:0] imm_i = 2'b00; // 12 bit
    localparam logic [1:0] imm_s = 2'b01; // 12 bit, split
    localparam logic [1:0] imm_b = 2'b10; // 13 bit, lsb zero
    localparam logic [1:0] imm_j = 2'b11; // 21 bit, lsb zero

    // branch conditions, codes 2 and 3 unused
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one 32 bit word, five views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage
